/* common/axi_sram_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, depths and enums for the AXI4 SRAM subsystem
// Host opcodes and the master and SRAM state encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package axi_sram_pkg;

    // AXI bus widths
    localparam int AXI_DATA_WIDTH = 32;
    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_ID_WIDTH   = 4;
    localparam int AXI_LEN_WIDTH  = 4;   // Beats minus one

    // Memory geometry
    localparam int MEM_ADDR_BITS = 8;    // 256 words
    localparam int BEAT_SHIFT    = 2;    // Byte to word address

    // FIFO geometry
    localparam int FIFO_DEPTH    = 16;
    localparam int FIFO_PTR_BITS = 5;    // Includes wrap bit

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } cmd_op_e;

    typedef enum logic [2:0] {
        M_IDLE,
        M_WADDR,
        M_WDATA,
        M_WRESP,
        M_RADDR,
        M_RDATA
    } master_state_e;

    typedef enum logic [1:0] {W_ADDR, W_DATA, W_RESP} sram_wr_state_e;

    typedef enum logic {R_ADDR, R_DATA} sram_rd_state_e;

endpackage

/* hdl/sync_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous FIFO with valid/ready on both sides
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 32
) (
    input  logic             ACLK,
    input  logic             ARESETn,
    input  logic [WIDTH-1:0] push_data,
    input  logic             push_valid,
    output logic             push_ready,
    output logic [WIDTH-1:0] pop_data,
    output logic             pop_valid,
    input  logic             pop_ready
);
    import axi_sram_pkg::*;

    logic [WIDTH-1:0]         mem [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0] wr_ptr;
    logic [FIFO_PTR_BITS-1:0] rd_ptr;
    logic                     full;
    logic                     empty;
    logic                     do_push;
    logic                     do_pop;

    // Same index, opposite wrap bit means full
    assign full  = (wr_ptr[FIFO_PTR_BITS-1] != rd_ptr[FIFO_PTR_BITS-1]) &&
                   (wr_ptr[FIFO_PTR_BITS-2:0] == rd_ptr[FIFO_PTR_BITS-2:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign push_ready = !full;
    assign pop_valid  = !empty;
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    assign pop_data = mem[rd_ptr[FIFO_PTR_BITS-2:0]];

    always_ff @(posedge ACLK) begin
        if (do_push) begin
            mem[wr_ptr[FIFO_PTR_BITS-2:0]] <= push_data;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* axi_burst_master/axi_burst_master.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 burst master, one outstanding write or read command at a time
// W beats come from the write FIFO, R beats go to the read FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module axi_burst_master (
    input  logic                                    ACLK,
    input  logic                                    ARESETn,
    // Host command
    input  logic                                    cmd_valid,
    output logic                                    cmd_ready,
    input  axi_sram_pkg::cmd_op_e                   cmd_op,
    input  logic [axi_sram_pkg::AXI_ADDR_WIDTH-1:0] cmd_addr,
    input  logic [axi_sram_pkg::AXI_LEN_WIDTH-1:0]  cmd_len,
    // Write FIFO side
    input  logic [axi_sram_pkg::AXI_DATA_WIDTH-1:0] wf_data,
    input  logic                                    wf_valid,
    output logic                                    wf_ready,
    // AW
    output logic                                    awvalid,
    input  logic                                    awready,
    output logic [axi_sram_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    output logic [axi_sram_pkg::AXI_ID_WIDTH-1:0]   awid,
    output logic [axi_sram_pkg::AXI_LEN_WIDTH-1:0]  awlen,
    // W
    output logic                                    wvalid,
    input  logic                                    wready,
    output logic [axi_sram_pkg::AXI_DATA_WIDTH-1:0] wdata,
    output logic                                    wlast,
    // B
    input  logic                                    bvalid,
    output logic                                    bready,
    input  logic [axi_sram_pkg::AXI_ID_WIDTH-1:0]   bid,
    // AR
    output logic                                    arvalid,
    input  logic                                    arready,
    output logic [axi_sram_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    output logic [axi_sram_pkg::AXI_ID_WIDTH-1:0]   arid,
    output logic [axi_sram_pkg::AXI_LEN_WIDTH-1:0]  arlen,
    // R
    input  logic                                    rvalid,
    output logic                                    rready,
    input  logic [axi_sram_pkg::AXI_DATA_WIDTH-1:0] rdata,
    input  logic                                    rlast,
    input  logic [axi_sram_pkg::AXI_ID_WIDTH-1:0]   rid,
    // Read FIFO side
    output logic [axi_sram_pkg::AXI_DATA_WIDTH-1:0] rf_data,
    output logic                                    rf_last,
    output logic                                    rf_valid,
    input  logic                                    rf_ready,
    output logic                                    id_error
);
    import axi_sram_pkg::*;

    master_state_e             state;
    logic [AXI_ADDR_WIDTH-1:0] addr_q;
    logic [AXI_LEN_WIDTH-1:0]  len_q;
    logic [AXI_LEN_WIDTH-1:0]  beat_q;   // W beats sent so far
    logic [AXI_ID_WIDTH-1:0]   id_q;
    logic                      w_hs;
    logic                      r_hs;

    assign cmd_ready = (state == M_IDLE);

    // Address channels share the latched command
    assign awvalid = (state == M_WADDR);
    assign awaddr  = addr_q;
    assign awid    = id_q;
    assign awlen   = len_q;
    assign arvalid = (state == M_RADDR);
    assign araddr  = addr_q;
    assign arid    = id_q;
    assign arlen   = len_q;

    // W beats pop straight off the write FIFO
    assign wvalid   = (state == M_WDATA) && wf_valid;
    assign wdata    = wf_data;
    assign wlast    = (beat_q == len_q);
    assign wf_ready = (state == M_WDATA) && wready;
    assign w_hs     = wvalid && wready;

    assign bready = (state == M_WRESP);

    // Back-pressure from the read FIFO
    assign rready   = (state == M_RDATA) && rf_ready;
    assign rf_valid = (state == M_RDATA) && rvalid;
    assign rf_data  = rdata;
    assign rf_last  = rlast;
    assign r_hs     = rvalid && rready;

    always_ff @(posedge ACLK) begin
        if (state == M_IDLE && cmd_valid) begin
            addr_q <= cmd_addr;
            len_q  <= cmd_len;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state    <= M_IDLE;
            beat_q   <= '0;
            id_q     <= '0;
            id_error <= 1'b0;
        end else begin
            id_error <= 1'b0;
            unique case (state)
                M_IDLE: begin
                    beat_q <= '0;
                    if (cmd_valid) begin
                        state <= (cmd_op == OP_WRITE) ? M_WADDR : M_RADDR;
                    end
                end
                M_WADDR: if (awready) state <= M_WDATA;
                M_WDATA: begin
                    if (w_hs) begin
                        beat_q <= beat_q + 1'b1;
                        if (wlast) begin
                            state <= M_WRESP;
                        end
                    end
                end
                M_WRESP: begin
                    if (bvalid) begin
                        id_error <= (bid != id_q);
                        id_q     <= id_q + 1'b1;   // Next command's ID
                        state    <= M_IDLE;
                    end
                end
                M_RADDR: if (arready) state <= M_RDATA;
                M_RDATA: begin
                    if (r_hs) begin
                        id_error <= (rid != id_q);
                        if (rlast) begin
                            id_q  <= id_q + 1'b1;
                            state <= M_IDLE;
                        end
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

endmodule

/* axi4_sram/axi4_sram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 SRAM slave, incrementing bursts over a word-addressed array
// Separate write and read state machines, responses always OKAY
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module axi4_sram (
    input  logic                                    ACLK,
    input  logic                                    ARESETn,
    input  logic                                    awvalid,
    output logic                                    awready,
    input  logic [axi_sram_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic [axi_sram_pkg::AXI_ID_WIDTH-1:0]   awid,
    input  logic [axi_sram_pkg::AXI_LEN_WIDTH-1:0]  awlen,
    input  logic                                    wvalid,
    output logic                                    wready,
    input  logic [axi_sram_pkg::AXI_DATA_WIDTH-1:0] wdata,
    input  logic                                    wlast,
    output logic                                    bvalid,
    input  logic                                    bready,
    output logic [axi_sram_pkg::AXI_ID_WIDTH-1:0]   bid,
    input  logic                                    arvalid,
    output logic                                    arready,
    input  logic [axi_sram_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic [axi_sram_pkg::AXI_ID_WIDTH-1:0]   arid,
    input  logic [axi_sram_pkg::AXI_LEN_WIDTH-1:0]  arlen,
    output logic                                    rvalid,
    input  logic                                    rready,
    output logic [axi_sram_pkg::AXI_DATA_WIDTH-1:0] rdata,
    output logic                                    rlast,
    output logic [axi_sram_pkg::AXI_ID_WIDTH-1:0]   rid
);
    import axi_sram_pkg::*;

    bit [AXI_DATA_WIDTH-1:0] mem [1 << MEM_ADDR_BITS];   // Starts at zero

    sram_wr_state_e           wr_state;
    logic [MEM_ADDR_BITS-1:0] wr_base;
    logic [AXI_LEN_WIDTH-1:0] wr_cnt;
    logic [AXI_ID_WIDTH-1:0]  wr_id;
    logic [MEM_ADDR_BITS-1:0] wr_idx;

    sram_rd_state_e           rd_state;
    logic [MEM_ADDR_BITS-1:0] rd_base;
    logic [AXI_LEN_WIDTH-1:0] rd_cnt;
    logic [AXI_LEN_WIDTH-1:0] rd_len;
    logic [AXI_ID_WIDTH-1:0]  rd_id;
    logic [MEM_ADDR_BITS-1:0] rd_idx;

    // Word index wraps modulo the depth
    assign wr_idx = wr_base + MEM_ADDR_BITS'(wr_cnt);
    assign rd_idx = rd_base + MEM_ADDR_BITS'(rd_cnt);

    assign awready = (wr_state == W_ADDR);
    assign wready  = (wr_state == W_DATA);
    assign bvalid  = (wr_state == W_RESP);
    assign bid     = wr_id;

    assign arready = (rd_state == R_ADDR);
    assign rvalid  = (rd_state == R_DATA);
    assign rdata   = mem[rd_idx];
    assign rlast   = rvalid && (rd_cnt == rd_len);
    assign rid     = rd_id;

    always_ff @(posedge ACLK) begin
        if (wvalid && wready) begin
            mem[wr_idx] <= wdata;
        end
    end

    // Burst base and ID are captured at the address handshake
    always_ff @(posedge ACLK) begin
        if (awvalid && awready) begin
            wr_base <= awaddr[BEAT_SHIFT +: MEM_ADDR_BITS];
            wr_id   <= awid;
        end
        if (arvalid && arready) begin
            rd_base <= araddr[BEAT_SHIFT +: MEM_ADDR_BITS];
            rd_len  <= arlen;
            rd_id   <= arid;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wr_state <= W_ADDR;
            wr_cnt   <= '0;
        end else begin
            unique case (wr_state)
                W_ADDR: begin
                    wr_cnt <= '0;
                    if (awvalid) wr_state <= W_DATA;
                end
                W_DATA: begin
                    if (wvalid) begin
                        wr_cnt <= wr_cnt + 1'b1;
                        if (wlast) wr_state <= W_RESP;   // Master marks the end
                    end
                end
                W_RESP: if (bready) wr_state <= W_ADDR;
                default: wr_state <= W_ADDR;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            rd_state <= R_ADDR;
            rd_cnt   <= '0;
        end else begin
            unique case (rd_state)
                R_ADDR: begin
                    rd_cnt <= '0;
                    if (arvalid) rd_state <= R_DATA;
                end
                R_DATA: begin
                    // Beat held while rready is low
                    if (rready) begin
                        if (rlast) begin
                            rd_state <= R_ADDR;
                        end else begin
                            rd_cnt <= rd_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* hdl/axi_sram_subsystem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level with host FIFOs, burst master and AXI4 SRAM slave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module axi_sram_subsystem (
    input  logic                                    ACLK,
    input  logic                                    ARESETn,
    input  logic                                    cmd_valid,
    output logic                                    cmd_ready,
    input  axi_sram_pkg::cmd_op_e                   cmd_op,
    input  logic [axi_sram_pkg::AXI_ADDR_WIDTH-1:0] cmd_addr,
    input  logic [axi_sram_pkg::AXI_LEN_WIDTH-1:0]  cmd_len,
    input  logic [axi_sram_pkg::AXI_DATA_WIDTH-1:0] wr_data,
    input  logic                                    wr_valid,
    output logic                                    wr_ready,
    output logic [axi_sram_pkg::AXI_DATA_WIDTH-1:0] rd_data,
    output logic                                    rd_last,
    output logic                                    rd_valid,
    input  logic                                    rd_ready,
    output logic                                    id_error
);
    import axi_sram_pkg::*;

    // Write FIFO to master
    logic [AXI_DATA_WIDTH-1:0] wf_data;
    logic                      wf_valid, wf_ready;
    // Master to read FIFO
    logic [AXI_DATA_WIDTH-1:0] rf_data;
    logic                      rf_last, rf_valid, rf_ready;
    // AXI4 between master and SRAM
    logic                      awvalid, awready, wvalid, wready, wlast;
    logic                      bvalid, bready, arvalid, arready;
    logic                      rvalid, rready, rlast;
    logic [AXI_ADDR_WIDTH-1:0] awaddr, araddr;
    logic [AXI_ID_WIDTH-1:0]   awid, bid, arid, rid;
    logic [AXI_LEN_WIDTH-1:0]  awlen, arlen;
    logic [AXI_DATA_WIDTH-1:0] wdata, rdata;

    sync_fifo #(.WIDTH(AXI_DATA_WIDTH)) u_wr_fifo (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .push_data(wr_data), .push_valid(wr_valid), .push_ready(wr_ready),
        .pop_data(wf_data), .pop_valid(wf_valid), .pop_ready(wf_ready)
    );

    // Last flag rides in the top bit
    sync_fifo #(.WIDTH(AXI_DATA_WIDTH + 1)) u_rd_fifo (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .push_data({rf_last, rf_data}), .push_valid(rf_valid), .push_ready(rf_ready),
        .pop_data({rd_last, rd_data}), .pop_valid(rd_valid), .pop_ready(rd_ready)
    );

    axi_burst_master u_master (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
        .cmd_addr(cmd_addr), .cmd_len(cmd_len),
        .wf_data(wf_data), .wf_valid(wf_valid), .wf_ready(wf_ready),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awid(awid), .awlen(awlen),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wlast(wlast),
        .bvalid(bvalid), .bready(bready), .bid(bid),
        .arvalid(arvalid), .arready(arready), .araddr(araddr), .arid(arid), .arlen(arlen),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rlast(rlast), .rid(rid),
        .rf_data(rf_data), .rf_last(rf_last), .rf_valid(rf_valid), .rf_ready(rf_ready),
        .id_error(id_error)
    );

    axi4_sram u_sram (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awid(awid), .awlen(awlen),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wlast(wlast),
        .bvalid(bvalid), .bready(bready), .bid(bid),
        .arvalid(arvalid), .arready(arready), .araddr(araddr), .arid(arid), .arlen(arlen),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rlast(rlast), .rid(rid)
    );

endmodule

/* verification/tb_axi_sram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AXI SRAM subsystem with a reference memory model
// LFSR stimulus, read-beat monitor, ID error watch and cycle timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_axi_sram;
    import axi_sram_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 8;
    localparam int          CYCLE_LIMIT  = 4000;   // ~300 beats x 10 with margin
    localparam int          RANDOM_CMDS  = 16;
    localparam logic [31:0] LFSR_SEED    = 32'd74691;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    logic                      ACLK = 1'b0;
    logic                      ARESETn;
    logic                      cmd_valid;
    logic                      cmd_ready;
    cmd_op_e                   cmd_op;
    logic [AXI_ADDR_WIDTH-1:0] cmd_addr;
    logic [AXI_LEN_WIDTH-1:0]  cmd_len;
    logic [AXI_DATA_WIDTH-1:0] wr_data;
    logic                      wr_valid;
    logic                      wr_ready;
    logic [AXI_DATA_WIDTH-1:0] rd_data;
    logic                      rd_last;
    logic                      rd_valid;
    logic                      rd_ready;
    logic                      id_error;

    logic [AXI_DATA_WIDTH-1:0] model_mem [1 << MEM_ADDR_BITS];
    logic [AXI_DATA_WIDTH-1:0] exp_data_q [$];
    logic                      exp_last_q [$];
    logic [31:0]               data_lfsr;
    logic [31:0]               ready_lfsr;
    logic                      throttle_on;   // Random rd_ready
    logic                      gaps_on;       // Random wr_valid gaps
    string                     current_test;
    int                        error_count;
    int                        test_start_errors;
    int                        tests_run;
    int                        tests_failed;
    int                        cycle_count;

    axi_sram_subsystem dut (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
        .cmd_addr(cmd_addr), .cmd_len(cmd_len),
        .wr_data(wr_data), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .rd_data(rd_data), .rd_last(rd_last), .rd_valid(rd_valid), .rd_ready(rd_ready),
        .id_error(id_error)
    );

    always #(CLK_PERIOD / 2) ACLK = ~ACLK;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            data_lfsr = lfsr_next(data_lfsr);
            value     = {value[30:0], data_lfsr[0]};
        end
        return value;
    endfunction

    // Reference word at base plus beat, modulo the depth
    function automatic logic [AXI_DATA_WIDTH-1:0] expected_word(
        input logic [MEM_ADDR_BITS-1:0] base, input int beat);
        logic [MEM_ADDR_BITS-1:0] idx;
        idx = base + MEM_ADDR_BITS'(beat);
        return model_mem[idx];
    endfunction

    task automatic check_word(input string name, input int beat,
                              input logic [AXI_DATA_WIDTH-1:0] expected,
                              input logic [AXI_DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s beat %0d rd_data: expected %h, actual %h",
                     name, beat, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_last(input string name, input int beat,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s beat %0d rd_last: expected %b, actual %b",
                     name, beat, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input string flag,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s: expected %b, actual %b",
                     name, flag, expected, actual);
            error_count++;
        end
    endtask

    task automatic push_word(input logic [AXI_DATA_WIDTH-1:0] word);
        wr_data  = word;
        wr_valid = 1'b1;
        do @(posedge ACLK); while (!wr_ready);
        @(negedge ACLK);
        wr_valid = 1'b0;
    endtask

    // Issue one command and wait until the master is idle again
    task automatic send_cmd(input cmd_op_e op, input logic [MEM_ADDR_BITS-1:0] base,
                            input int beats);
        cmd_op    = op;
        cmd_addr  = AXI_ADDR_WIDTH'(base) << BEAT_SHIFT;
        cmd_len   = AXI_LEN_WIDTH'(beats - 1);
        cmd_valid = 1'b1;
        do @(posedge ACLK); while (!cmd_ready);
        @(negedge ACLK);
        cmd_valid = 1'b0;
        do @(posedge ACLK); while (!cmd_ready);
        @(negedge ACLK);
    endtask

    task automatic write_burst(input logic [MEM_ADDR_BITS-1:0] base, input int beats);
        logic [AXI_DATA_WIDTH-1:0] words [1 << AXI_LEN_WIDTH];
        logic [MEM_ADDR_BITS-1:0]  idx;
        int                        i;
        for (i = 0; i < beats; i++) begin
            words[i]       = take_bits(AXI_DATA_WIDTH);
            idx            = base + MEM_ADDR_BITS'(i);
            model_mem[idx] = words[i];
        end
        fork
            begin
                for (i = 0; i < beats; i++) begin
                    if (gaps_on && take_bits(1) != 0) @(negedge ACLK);   // Idle cycle
                    push_word(words[i]);
                end
            end
            send_cmd(OP_WRITE, base, beats);
        join
    endtask

    task automatic read_burst(input logic [MEM_ADDR_BITS-1:0] base, input int beats);
        int i;
        for (i = 0; i < beats; i++) begin
            exp_data_q.push_back(expected_word(base, i));
            exp_last_q.push_back(i == beats - 1);
        end
        send_cmd(OP_READ, base, beats);
    endtask

    task automatic start_test(input string name);
        current_test      = name;
        test_start_errors = error_count;
    endtask

    task automatic end_test();
        int errors;
        while (exp_data_q.size() != 0) @(posedge ACLK);   // Host drains the read FIFO
        @(negedge ACLK);
        errors = error_count - test_start_errors;
        tests_run++;
        if (errors == 0) begin
            $display("Test %s: finished, 0 errors", current_test);
        end else begin
            tests_failed++;
            $display("Test %s: finished, %0d errors", current_test, errors);
        end
    endtask

    // Read beats leave the FIFO on rd_valid and rd_ready
    initial begin : read_monitor
        logic [AXI_DATA_WIDTH-1:0] exp_word;
        logic                      exp_last;
        int                        beat;
        beat = 0;
        forever begin
            @(posedge ACLK);
            if (ARESETn && rd_valid && rd_ready) begin
                if (exp_data_q.size() == 0) begin
                    $display("%s: read beat arrived with no read outstanding", current_test);
                    error_count++;
                end else begin
                    exp_word = exp_data_q.pop_front();
                    exp_last = exp_last_q.pop_front();
                    check_word(current_test, beat, exp_word, rd_data);
                    check_last(current_test, beat, exp_last, rd_last);
                    beat = exp_last ? 0 : beat + 1;
                end
            end
        end
    end

    always @(posedge ACLK) begin
        if (ARESETn && id_error) begin
            $display("%s: response ID did not match the issued ID", current_test);
            error_count++;
        end
    end

    initial begin : ready_driver
        ready_lfsr = ~LFSR_SEED;   // Own stream for the ready pattern
        rd_ready   = 1'b0;
        forever begin
            @(negedge ACLK);
            if (throttle_on) begin
                ready_lfsr = lfsr_next(ready_lfsr);
                rd_ready   = ready_lfsr[0];
            end else begin
                rd_ready = ARESETn;
            end
        end
    end

    initial begin : cycle_watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge ACLK);
            cycle_count++;
        end
        $display("Timeout in %s: run stopped after %0d cycles", current_test, cycle_count);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        logic [MEM_ADDR_BITS-1:0] base;
        logic [MEM_ADDR_BITS-1:0] last_base;
        int                       beats;
        int                       n;
        for (n = 0; n < (1 << MEM_ADDR_BITS); n++) begin
            model_mem[n] = '0;
        end
        data_lfsr    = LFSR_SEED;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        throttle_on  = 1'b0;
        gaps_on      = 1'b0;
        current_test = "reset_state";
        ARESETn      = 1'b0;
        cmd_valid    = 1'b0;
        cmd_op       = OP_WRITE;
        cmd_addr     = '0;
        cmd_len      = '0;
        wr_data      = '0;
        wr_valid     = 1'b0;
        repeat (RESET_CYCLES) @(negedge ACLK);
        ARESETn = 1'b1;
        @(negedge ACLK);

        start_test("reset_state");
        check_flag(current_test, "cmd_ready", 1'b1, cmd_ready);
        check_flag(current_test, "rd_valid", 1'b0, rd_valid);
        check_flag(current_test, "wr_ready", 1'b1, wr_ready);
        end_test();

        start_test("single_beat");
        write_burst(8'd100, 1);
        read_burst(8'd100, 1);
        end_test();

        start_test("burst_16");
        write_burst(8'd32, 16);
        read_burst(8'd32, 16);
        end_test();

        // 250..255 then 0..9, neighbours must stay untouched
        start_test("wrap_burst");
        write_burst(8'd250, 16);
        read_burst(8'd250, 16);
        read_burst(8'd244, 6);
        read_burst(8'd10, 6);
        end_test();

        start_test("unwritten_read");
        read_burst(8'd180, 4);
        end_test();

        start_test("random_mixed");
        throttle_on = 1'b1;
        gaps_on     = 1'b1;
        last_base   = '0;
        for (n = 0; n < RANDOM_CMDS; n++) begin
            base  = MEM_ADDR_BITS'(take_bits(MEM_ADDR_BITS));
            beats = int'(take_bits(AXI_LEN_WIDTH)) + 1;
            if (take_bits(1) != 0) begin
                if (take_bits(1) != 0) base = last_base;   // Revisit fresh data
                read_burst(base, beats);
            end else begin
                write_burst(base, beats);
                last_base = base;
            end
        end
        end_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* compile.f */
common/axi_sram_pkg.sv
hdl/sync_fifo.sv
axi_burst_master/axi_burst_master.sv
axi4_sram/axi4_sram.sv
hdl/axi_sram_subsystem.sv
verification/tb_axi_sram.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AXI SRAM subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_axi_sram -Mdir obj_dir -o sim_axi_sram -f compile.f

./obj_dir/sim_axi_sram > sim.log
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished cleanly"
